// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rvIsaPkg.sv
  - hdl/rvSocPkg.sv
  - hdl/decodeUnit.sv
  - hdl/regFile.sv
  - hdl/stageReg.sv
  - hdl/executeUnit.sv
  - hdl/hazardUnit.sv
  - hdl/memArbiter.sv
  - hdl/rvCoreTop.sv
  - target: test
    files:
      - tb/rvCoreTb.sv

// File: flist.f
hdl/rvIsaPkg.sv
hdl/rvSocPkg.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/stageReg.sv
hdl/executeUnit.sv
hdl/hazardUnit.sv
hdl/memArbiter.sv
hdl/rvCoreTop.sv
tb/rvCoreTb.sv

// File: hdl/decodeUnit.sv
module decodeUnit (
    input  logic [rvIsaPkg::XLEN-1:0] instr,
    output rvSocPkg::ctrlT            ctrl,
    output logic [rvIsaPkg::XLEN-1:0] imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rvIsaPkg::immKindE immKind;

    assign opcode = instr[6:0];
    assign funct3 = instr[rvIsaPkg::FUNCT3_LSB +: 3];
    assign funct7 = instr[rvIsaPkg::FUNCT7_LSB +: 7];

    always_comb begin
        ctrl = '0;
        immKind = rvIsaPkg::IMM_I;
        case (opcode)
            rvIsaPkg::OP_OP: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    rvIsaPkg::F3_ADD: begin
                        ctrl.aluOp = (funct7 == rvIsaPkg::F7_SUB) ?
                            rvIsaPkg::ALU_SUB : rvIsaPkg::ALU_ADD;
                    end
                    rvIsaPkg::F3_SLT: ctrl.aluOp = rvIsaPkg::ALU_SLT;
                    rvIsaPkg::F3_XOR: ctrl.aluOp = rvIsaPkg::ALU_XOR;
                    rvIsaPkg::F3_OR:  ctrl.aluOp = rvIsaPkg::ALU_OR;
                    rvIsaPkg::F3_AND: ctrl.aluOp = rvIsaPkg::ALU_AND;
                    default:          ctrl.regWrite = 1'b0;
                endcase
                // Only SUB may carry a nonzero funct7
                if (funct7 != 7'b0 &&
                    !(funct7 == rvIsaPkg::F7_SUB && funct3 == rvIsaPkg::F3_ADD)) begin
                    ctrl = '0;
                end
            end
            rvIsaPkg::OP_OP_IMM: begin
                if (funct3 == rvIsaPkg::F3_ADD) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
            end
            rvIsaPkg::OP_LOAD: begin
                if (funct3 == rvIsaPkg::F3_WORD) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
            end
            rvIsaPkg::OP_STORE: begin
                immKind = rvIsaPkg::IMM_S;
                if (funct3 == rvIsaPkg::F3_WORD) begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
            end
            rvIsaPkg::OP_BRANCH: begin
                immKind = rvIsaPkg::IMM_B;
                ctrl.branch = (funct3 == rvIsaPkg::F3_BEQ);
            end
            rvIsaPkg::OP_JAL: begin
                immKind = rvIsaPkg::IMM_J;
                ctrl.regWrite = 1'b1;
                ctrl.jump = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        case (immKind)
            rvIsaPkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvIsaPkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                    instr[30:25], instr[11:8], 1'b0};
            rvIsaPkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                    instr[20], instr[30:21], 1'b0};
            default:         imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// File: hdl/executeUnit.sv
module executeUnit (
    input  rvSocPkg::idExT            idEx,
    input  logic                      fwdA,
    input  logic                      fwdB,
    input  logic [rvIsaPkg::XLEN-1:0] memResult,
    output rvSocPkg::exMemT           exMem,
    output logic                      redirect,
    output logic [rvIsaPkg::XLEN-1:0] target
);

    logic [rvIsaPkg::XLEN-1:0] opA;
    logic [rvIsaPkg::XLEN-1:0] opB;
    logic [rvIsaPkg::XLEN-1:0] aluB;
    logic [rvIsaPkg::XLEN-1:0] aluOut;
    logic taken;

    // Operands from the MEM stage override stale register reads
    assign opA = fwdA ? memResult : idEx.rs1Val;
    assign opB = fwdB ? memResult : idEx.rs2Val;
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            rvIsaPkg::ALU_SUB: aluOut = opA - aluB;
            rvIsaPkg::ALU_AND: aluOut = opA & aluB;
            rvIsaPkg::ALU_OR:  aluOut = opA | aluB;
            rvIsaPkg::ALU_XOR: aluOut = opA ^ aluB;
            rvIsaPkg::ALU_SLT: begin
                aluOut = {{(rvIsaPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            end
            default:           aluOut = opA + aluB;
        endcase
    end

    assign taken = (idEx.ctrl.branch && opA == opB) || idEx.ctrl.jump;
    assign redirect = idEx.valid && taken;
    assign target = idEx.pc + idEx.imm;

    always_comb begin
        exMem.valid = idEx.valid;
        exMem.ctrl = idEx.ctrl;
        // JAL links pc+4
        exMem.aluResult = idEx.ctrl.jump ? idEx.pcPlus4 : aluOut;
        exMem.storeVal = opB;
        exMem.rd = idEx.rd;
    end

endmodule

// File: hdl/hazardUnit.sv
module hazardUnit (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [rvIsaPkg::REG_AW-1:0] idRs1,
    input  logic [rvIsaPkg::REG_AW-1:0] idRs2,
    input  logic [rvIsaPkg::REG_AW-1:0] memRd,
    input  logic                        memRegWrite,
    input  logic                        memValid,
    input  logic                        memReq,
    input  logic                        memGrant,
    input  logic                        redirect,
    output logic                        fwdA,
    output logic                        fwdB,
    output logic                        stall,
    output logic                        flush
);

    logic memWrites;

    assign memWrites = memValid && memRegWrite && memRd != '0;

    assign fwdA = memWrites && memRd == idRs1;
    assign fwdB = memWrites && memRd == idRs2;

    assign stall = memReq && !memGrant;
    assign flush = redirect;

    // APB access cycles never come back to back, so one stall cycle at most
    assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall);

endmodule

// File: hdl/memArbiter.sv
module memArbiter (
    input  logic                           clk,
    input  logic                           rstN,
    input  rvSocPkg::apbReqT               apbReq,
    output logic [rvIsaPkg::XLEN-1:0]      prdata,
    output logic                           pready,
    input  logic                           coreRead,
    input  logic                           coreWrite,
    input  logic [rvIsaPkg::XLEN-1:0]      coreAddr,
    input  logic [rvIsaPkg::XLEN-1:0]      coreWdata,
    output logic [rvIsaPkg::XLEN-1:0]      coreRdata,
    output logic                           memGrant,
    output logic                           imemWe,
    output logic [rvSocPkg::IMEM_AW-1:0]   imemAddr,
    output logic [rvIsaPkg::XLEN-1:0]      imemWdata
);

    logic [rvIsaPkg::XLEN-1:0] dmem [rvSocPkg::DMEM_WORDS];
    logic [rvSocPkg::DMEM_AW-1:0] hostIdx;
    logic [rvSocPkg::DMEM_AW-1:0] coreIdx;
    logic hostAccess;
    logic hostDmem;
    logic hostWe;
    logic coreWe;

    assign hostAccess = apbReq.psel && apbReq.penable;
    assign hostDmem = hostAccess && |(apbReq.paddr & rvSocPkg::DMEM_BASE);
    assign hostIdx = apbReq.paddr[rvSocPkg::DMEM_AW+1:2];
    assign coreIdx = coreAddr[rvSocPkg::DMEM_AW+1:2];

    // Every access completes in its first access cycle
    assign pready = hostAccess;
    assign prdata = (hostDmem && !apbReq.pwrite) ? dmem[hostIdx] : '0;

    // Host wins the data memory
    assign memGrant = !hostDmem;
    assign hostWe = hostDmem && apbReq.pwrite;
    assign coreWe = coreWrite && memGrant;
    assign coreRdata = coreRead ? dmem[coreIdx] : '0;

    always_ff @(posedge clk) begin
        if (hostWe) begin
            dmem[hostIdx] <= apbReq.pwdata;
        end else if (coreWe) begin
            dmem[coreIdx] <= coreWdata;
        end
    end

    assign imemWe = hostAccess && apbReq.pwrite && !hostDmem;
    assign imemAddr = apbReq.paddr[rvSocPkg::IMEM_AW+1:2];
    assign imemWdata = apbReq.pwdata;

    // A held-back store waits in EX/MEM and goes in the following cycle
    assert property (@(posedge clk) disable iff (!rstN)
        (coreWrite && !memGrant) |=> (coreWrite && memGrant));

endmodule

// File: hdl/regFile.sv
module regFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [rvIsaPkg::REG_AW-1:0] rs1,
    input  logic [rvIsaPkg::REG_AW-1:0] rs2,
    output logic [rvIsaPkg::XLEN-1:0]   rs1Val,
    output logic [rvIsaPkg::XLEN-1:0]   rs2Val,
    input  logic                        we,
    input  logic [rvIsaPkg::REG_AW-1:0] rd,
    input  logic [rvIsaPkg::XLEN-1:0]   wd
);

    logic [rvIsaPkg::XLEN-1:0] regs [31:1];
    logic writing;

    assign writing = we && rd != '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[rd] <= wd;
        end
    end

    // Bypass covers the writer two instructions ahead
    assign rs1Val = (rs1 == '0) ? '0 : (writing && rd == rs1) ? wd : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : (writing && rd == rs2) ? wd : regs[rs2];

    // x0 write leaves the next read of an unchanged index untouched
    assert property (@(posedge clk) disable iff (!rstN)
        (we && rd == '0) ##1 (rs1 == $past(rs1) && !(writing && rd == rs1))
        |-> rs1Val == $past(rs1Val));

endmodule

// File: hdl/rvCoreTop.sv
module rvCoreTop (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      run,
    input  rvSocPkg::apbReqT          apbReq,
    output logic [rvIsaPkg::XLEN-1:0] prdata,
    output logic                      pready,
    output rvSocPkg::retireT          retire
);

    logic [rvIsaPkg::XLEN-1:0] pc;
    logic [rvIsaPkg::XLEN-1:0] imem [rvSocPkg::IMEM_WORDS];
    logic imemWe;
    logic [rvSocPkg::IMEM_AW-1:0] imemAddr;
    logic [rvIsaPkg::XLEN-1:0] imemWdata;

    rvSocPkg::ifIdT ifIdD;
    rvSocPkg::ifIdT ifIdQ;
    rvSocPkg::idExT idExD;
    rvSocPkg::idExT idExQ;
    rvSocPkg::exMemT exMemD;
    rvSocPkg::exMemT exMemQ;
    rvSocPkg::ctrlT idCtrl;
    logic [rvIsaPkg::XLEN-1:0] idImm;
    logic [rvIsaPkg::XLEN-1:0] rs1Val;
    logic [rvIsaPkg::XLEN-1:0] rs2Val;
    logic [rvIsaPkg::REG_AW-1:0] idRs1;
    logic [rvIsaPkg::REG_AW-1:0] idRs2;

    logic fwdA;
    logic fwdB;
    logic stall;
    logic flush;
    logic redirect;
    logic [rvIsaPkg::XLEN-1:0] target;
    logic memReq;
    logic memGrant;
    logic coreRead;
    logic coreWrite;
    logic [rvIsaPkg::XLEN-1:0] loadData;
    logic [rvIsaPkg::XLEN-1:0] wbData;
    logic wbEn;

    // Fetch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!stall) begin
            if (redirect) begin
                pc <= target;
            end else if (run) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemWdata;
        end
    end

    always_comb begin
        ifIdD = '0;
        if (run) begin
            ifIdD.valid = 1'b1;
            ifIdD.pc = pc;
            ifIdD.instr = imem[pc[rvSocPkg::IMEM_AW+1:2]];
        end
    end

    stageReg #(.payloadT(rvSocPkg::ifIdT)) u_ifId (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush), .d(ifIdD), .q(ifIdQ)
    );

    // Decode
    assign idRs1 = ifIdQ.instr[rvIsaPkg::RS1_LSB +: rvIsaPkg::REG_AW];
    assign idRs2 = ifIdQ.instr[rvIsaPkg::RS2_LSB +: rvIsaPkg::REG_AW];

    decodeUnit u_decode (.instr(ifIdQ.instr), .ctrl(idCtrl), .imm(idImm));

    regFile u_regFile (
        .clk(clk), .rstN(rstN), .rs1(idRs1), .rs2(idRs2),
        .rs1Val(rs1Val), .rs2Val(rs2Val),
        .we(wbEn), .rd(exMemQ.rd), .wd(wbData)
    );

    always_comb begin
        idExD.valid = ifIdQ.valid;
        idExD.ctrl = idCtrl;
        idExD.rs1Val = rs1Val;
        idExD.rs2Val = rs2Val;
        idExD.pc = ifIdQ.pc;
        idExD.rs1 = idRs1;
        idExD.rs2 = idRs2;
        idExD.rd = ifIdQ.instr[rvIsaPkg::RD_LSB +: rvIsaPkg::REG_AW];
        idExD.imm = idImm;
        idExD.pcPlus4 = ifIdQ.pc + 32'd4;
    end

    stageReg #(.payloadT(rvSocPkg::idExT)) u_idEx (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush), .d(idExD), .q(idExQ)
    );

    // Execute
    executeUnit u_execute (
        .idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB), .memResult(wbData),
        .exMem(exMemD), .redirect(redirect), .target(target)
    );

    stageReg #(.payloadT(rvSocPkg::exMemT)) u_exMem (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(1'b0), .d(exMemD), .q(exMemQ)
    );

    // Memory and write-back
    assign coreRead = exMemQ.valid && exMemQ.ctrl.memRead;
    assign coreWrite = exMemQ.valid && exMemQ.ctrl.memWrite;
    assign memReq = coreRead || coreWrite;

    memArbiter u_memArbiter (
        .clk(clk), .rstN(rstN), .apbReq(apbReq), .prdata(prdata), .pready(pready),
        .coreRead(coreRead), .coreWrite(coreWrite),
        .coreAddr(exMemQ.aluResult), .coreWdata(exMemQ.storeVal),
        .coreRdata(loadData), .memGrant(memGrant),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemWdata(imemWdata)
    );

    assign wbData = exMemQ.ctrl.memRead ? loadData : exMemQ.aluResult;
    // No write while a denied load waits
    assign wbEn = exMemQ.valid && exMemQ.ctrl.regWrite && !stall;

    hazardUnit u_hazard (
        .clk(clk), .rstN(rstN), .idRs1(idExQ.rs1), .idRs2(idExQ.rs2),
        .memRd(exMemQ.rd), .memRegWrite(exMemQ.ctrl.regWrite), .memValid(exMemQ.valid),
        .memReq(memReq), .memGrant(memGrant), .redirect(redirect),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
    );

    always_comb begin
        retire.valid = wbEn && exMemQ.rd != '0;
        retire.rd = exMemQ.rd;
        retire.data = wbData;
    end

endmodule

// File: hdl/rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;

    // Instruction field positions
    localparam int RD_LSB = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [6:0] OP_OP = 7'b0110011;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ADD must stay zero so a bubble decodes as a harmless add
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } aluOpE;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} immKindE;

endpackage

// File: hdl/rvSocPkg.sv
package rvSocPkg;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // APB address bit 12 picks data memory
    localparam logic [rvIsaPkg::XLEN-1:0] DMEM_BASE = 32'h0000_1000;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic aluSrcImm;
        logic branch;
        logic jump;
        rvIsaPkg::aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic valid;
        logic [rvIsaPkg::XLEN-1:0] pc;
        logic [rvIsaPkg::XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        logic [rvIsaPkg::XLEN-1:0] rs1Val;
        logic [rvIsaPkg::XLEN-1:0] rs2Val;
        logic [rvIsaPkg::XLEN-1:0] pc;
        logic [rvIsaPkg::REG_AW-1:0] rs1;
        logic [rvIsaPkg::REG_AW-1:0] rs2;
        logic [rvIsaPkg::REG_AW-1:0] rd;
        logic [rvIsaPkg::XLEN-1:0] imm;
        logic [rvIsaPkg::XLEN-1:0] pcPlus4;
    } idExT;

    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        logic [rvIsaPkg::XLEN-1:0] aluResult;
        logic [rvIsaPkg::XLEN-1:0] storeVal;
        logic [rvIsaPkg::REG_AW-1:0] rd;
    } exMemT;

    typedef struct packed {
        logic valid;
        logic [rvIsaPkg::REG_AW-1:0] rd;
        logic [rvIsaPkg::XLEN-1:0] data;
    } retireT;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [rvIsaPkg::XLEN-1:0] paddr;
        logic [rvIsaPkg::XLEN-1:0] pwdata;
    } apbReqT;

endpackage

// File: hdl/stageReg.sv
module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Stall wins over flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (!stall) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

// File: tb/rvCoreTb.sv
module rvCoreTb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int PROGRAM_CYCLES = 200;
    localparam int APB_CYCLES = 10;
    localparam int RT_WORDS = 16;
    localparam int HOST_READS = 20;
    localparam int PROGRAM_RUNS = 4;
    localparam int MAX_PROG_WORDS = 48;
    // Round trip, host reads, then load, clear and read-back of each program
    localparam int APB_TRANSFERS = 2 * RT_WORDS + HOST_READS
                                   + PROGRAM_RUNS * 2 * MAX_PROG_WORDS;
    localparam int WATCHDOG_CYCLES = PROGRAM_RUNS * PROGRAM_CYCLES
                                     + APB_TRANSFERS * APB_CYCLES
                                     + (PROGRAM_RUNS + 1) * (RESET_CYCLES + 1);
    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam logic [11:0] MARKER = 12'h155;
    localparam logic [4:0] DONE_REG = 5'd31;

    logic clk;
    logic rstN;
    logic run;
    rvSocPkg::apbReqT apbReq;
    logic [31:0] prdata;
    logic pready;
    rvSocPkg::retireT retire;

    integer seed;
    int errors;
    int testsPassed;
    int testsFailed;
    logic [31:0] prog [$];
    logic [31:0] shadow [rvSocPkg::DMEM_WORDS];
    int written [$];
    logic [31:0] aluExp [9];
    logic [11:0] c1;
    logic [11:0] c2;

    rvCoreTop u_dut (
        .clk(clk), .rstN(rstN), .run(run), .apbReq(apbReq),
        .prdata(prdata), .pready(pready), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Data memory access cycles complete at once
    assert property (@(posedge clk) disable iff (!rstN)
        (apbReq.psel && apbReq.penable && (apbReq.paddr & rvSocPkg::DMEM_BASE) != 0)
        |-> pready)
    else begin
        $display("FAILED pready: got %h expected 1 in a data memory access cycle", pready);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rstN) retire.valid |-> retire.rd != 5'd0)
    else begin
        $display("FAILED retire.rd: got %h with valid high, data %h", retire.rd, retire.data);
        errors++;
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, rvIsaPkg::F3_ADD, rd, rvIsaPkg::OP_OP_IMM};
    endfunction

    function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rvIsaPkg::OP_OP};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, rvIsaPkg::F3_WORD, rd, rvIsaPkg::OP_LOAD};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, rvIsaPkg::F3_WORD, imm[4:0], rvIsaPkg::OP_STORE};
    endfunction

    function automatic logic [31:0] beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, rvIsaPkg::F3_BEQ, off[4:1], off[11],
                rvIsaPkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::OP_JAL};
    endfunction

    task automatic resetCore();
        @(posedge clk);
        rstN <= 1'b0;
        run <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic apbTransfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        rvSocPkg::apbReqT req;
        int waited;
        req = '0;
        req.psel = 1'b1;
        req.pwrite = write;
        req.paddr = addr;
        req.pwdata = wdata;
        @(posedge clk);
        apbReq <= req;
        @(posedge clk);
        apbReq.penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < APB_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        rdata = prdata;
        if (!pready) begin
            $display("APB transfer to address %h never saw pready", addr);
            errors++;
        end
        @(posedge clk);
        apbReq <= '0;
    endtask

    task automatic dmemWrite(input int word, input logic [31:0] data);
        logic [31:0] unused;
        apbTransfer(1'b1, rvSocPkg::DMEM_BASE | (32'(word) << 2), data, unused);
        shadow[word] = data;
    endtask

    task automatic checkWord(input int word, input logic [31:0] expected, input string what);
        logic [31:0] got;
        apbTransfer(1'b0, rvSocPkg::DMEM_BASE | (32'(word) << 2), '0, got);
        assert (got === expected)
        else begin
            $display("FAILED prdata at word %0d (%s): got %h expected %h",
                     word, what, got, expected);
            errors++;
        end
    endtask

    task automatic loadProgram();
        logic [31:0] unused;
        // Final loop also marks the end of the run
        prog.push_back(jal(DONE_REG, 21'd0));
        for (int i = 0; i < prog.size(); i++) begin
            apbTransfer(1'b1, 32'(i) << 2, prog[i], unused);
        end
    endtask

    task automatic runProgram(input string name);
        int cycles;
        logic done;
        logic [31:0] link;
        // Final JAL sits in the last word and links the word after it
        link = 32'(prog.size()) << 2;
        @(posedge clk);
        run <= 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < PROGRAM_CYCLES) begin
            @(negedge clk);
            done = retire.valid && retire.rd == DONE_REG;
            cycles++;
        end
        if (!done) begin
            $display("%s program did not reach its final loop in %0d cycles",
                     name, PROGRAM_CYCLES);
            errors++;
        end else begin
            assert (retire.data === link)
            else begin
                $display("FAILED retire.data: got %h expected %h", retire.data, link);
                errors++;
            end
        end
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic pushPadded(input logic [31:0] instr, input int pad);
        prog.push_back(instr);
        repeat (pad) prog.push_back(NOP);
    endtask

    task automatic buildAluProgram();
        logic [31:0] a;
        logic [31:0] b;
        a = sext12(c1);
        b = sext12(c2);
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, c1));
        prog.push_back(addi(5'd2, 5'd0, c2));
        prog.push_back(rOp(7'h00, rvIsaPkg::F3_ADD, 5'd3, 5'd1, 5'd2));
        prog.push_back(rOp(rvIsaPkg::F7_SUB, rvIsaPkg::F3_ADD, 5'd4, 5'd1, 5'd2));
        prog.push_back(rOp(7'h00, rvIsaPkg::F3_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(rOp(7'h00, rvIsaPkg::F3_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(rOp(7'h00, rvIsaPkg::F3_XOR, 5'd7, 5'd1, 5'd2));
        prog.push_back(rOp(7'h00, rvIsaPkg::F3_SLT, 5'd8, 5'd1, 5'd2));
        prog.push_back(rOp(7'h00, rvIsaPkg::F3_SLT, 5'd9, 5'd2, 5'd1));
        for (int r = 1; r <= 9; r++) begin
            prog.push_back(sw(5'(r), 5'd0, 12'((r - 1) * 4)));
        end
        aluExp[0] = a;
        aluExp[1] = b;
        aluExp[2] = a + b;
        aluExp[3] = a - b;
        aluExp[4] = a & b;
        aluExp[5] = a | b;
        aluExp[6] = a ^ b;
        aluExp[7] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        aluExp[8] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    endtask

    // Dependent chain with a load used right away
    task automatic appendChain(input int base, input int pad, input logic [11:0] a);
        pushPadded(addi(5'd1, 5'd0, a), pad);
        pushPadded(rOp(7'h00, rvIsaPkg::F3_ADD, 5'd2, 5'd1, 5'd1), pad);
        pushPadded(rOp(rvIsaPkg::F7_SUB, rvIsaPkg::F3_ADD, 5'd3, 5'd2, 5'd1), pad);
        pushPadded(sw(5'd3, 5'd0, 12'(base)), pad);
        pushPadded(lw(5'd4, 5'd0, 12'(base)), pad);
        pushPadded(rOp(7'h00, rvIsaPkg::F3_ADD, 5'd5, 5'd4, 5'd2), pad);
        pushPadded(rOp(7'h00, rvIsaPkg::F3_XOR, 5'd6, 5'd5, 5'd4), pad);
        pushPadded(sw(5'd6, 5'd0, 12'(base + 4)), pad);
        pushPadded(sw(5'd5, 5'd0, 12'(base + 8)), pad);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            testsPassed++;
            $display("%s ok", name);
        end else begin
            testsFailed++;
            $display("%s %0d error(s)", name, errors - errorsBefore);
        end
    endtask

    initial begin
        int mark;
        int word;
        int idx;
        int jalIdx;
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] chainExp [3];
        seed = 32'h9ec50f79;
        rstN = 1'b0;
        run = 1'b0;
        apbReq = '0;
        errors = 0;
        testsPassed = 0;
        testsFailed = 0;
        resetCore();

        mark = errors;
        for (int i = 0; i < RT_WORDS; i++) begin
            word = 128 + ($random(seed) & 127);
            dmemWrite(word, $random(seed));
            written.push_back(word);
        end
        foreach (written[i]) begin
            checkWord(written[i], shadow[written[i]], "round trip");
        end
        finishTest("1 APB round trip", mark);

        mark = errors;
        rnd = $random(seed);
        c1 = rnd[11:0];
        rnd = $random(seed);
        c2 = rnd[11:0];
        buildAluProgram();
        loadProgram();
        runProgram("ALU");
        for (int i = 0; i < 9; i++) begin
            checkWord(i, aluExp[i], "ALU result");
        end
        finishTest("2 ALU results", mark);

        mark = errors;
        resetCore();
        rnd = $random(seed);
        a = sext12(rnd[11:0]);
        chainExp[0] = a;
        chainExp[1] = (3 * a) ^ a;
        chainExp[2] = 3 * a;
        prog.delete();
        appendChain(64, 0, rnd[11:0]);
        appendChain(96, 3, rnd[11:0]);
        loadProgram();
        runProgram("forwarding");
        for (int i = 0; i < 3; i++) begin
            checkWord(24 + i, chainExp[i], "padded chain");
            checkWord(16 + i, chainExp[i], "back-to-back chain");
        end
        finishTest("3 forwarding", mark);

        mark = errors;
        resetCore();
        for (int i = 32; i <= 36; i++) begin
            dmemWrite(i, 32'd0);
        end
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd2, 5'd0, 12'd5));
        prog.push_back(addi(5'd3, 5'd0, MARKER));
        prog.push_back(beq(5'd1, 5'd2, 13'd12));
        prog.push_back(sw(5'd3, 5'd0, 12'd128));
        prog.push_back(sw(5'd3, 5'd0, 12'd132));
        jalIdx = prog.size();
        prog.push_back(jal(5'd5, 21'd12));
        prog.push_back(sw(5'd3, 5'd0, 12'd136));
        prog.push_back(sw(5'd3, 5'd0, 12'd140));
        prog.push_back(sw(5'd5, 5'd0, 12'd144));
        loadProgram();
        runProgram("branch");
        for (int i = 32; i <= 35; i++) begin
            checkWord(i, 32'd0, "skipped store");
        end
        checkWord(36, 32'(jalIdx * 4 + 4), "JAL link");
        finishTest("4 branch and jump", mark);

        mark = errors;
        resetCore();
        buildAluProgram();
        loadProgram();
        for (int i = 0; i < 9; i++) begin
            dmemWrite(i, 32'd0);
        end
        fork
            runProgram("contention");
            begin
                repeat (HOST_READS) begin
                    idx = ($random(seed) & 32'h7fff_ffff) % written.size();
                    checkWord(written[idx], shadow[written[idx]], "host read");
                end
            end
        join
        for (int i = 0; i < 9; i++) begin
            checkWord(i, aluExp[i], "ALU result rerun");
        end
        finishTest("5 contention", mark);

        $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
